//--- tlk_tx_pkg.sv
// shared definitions for the TLK2711 transmit framer, normal mode only
// frame lengths are in bytes and are assumed even and nonzero
`default_nettype none

package tlk_tx_pkg;

    ////////////////////////////////////////////////////////////
    // 8b/10b control and data characters
    ////////////////////////////////////////////////////////////
    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;
    localparam logic [7:0] K27_7 = 8'hFB;
    localparam logic [7:0] K28_2 = 8'h5C;
    localparam logic [7:0] K29_7 = 8'hFD;
    localparam logic [7:0] K30_7 = 8'hFE;

    // frame header and type marks
    localparam logic [15:0] HEAD_0   = 16'hEB90;
    localparam logic [15:0] HEAD_1   = 16'hE116;
    localparam logic [7:0]  TX_IND   = 8'h81;
    localparam logic [7:0]  FILE_END = 8'h01;

    typedef enum logic [3:0] {
        idle, sync, sof, head, file_sign, frame_num, dlen, data, tail, eof, gap
    } tx_state_e;

    // one symbol pair on the serializer bus
    typedef struct packed {
        logic        tk_msb;
        logic        tk_lsb;
        logic [15:0] data;
    } line_sym_t;

    typedef struct packed {
        logic [15:0] body_len;
        logic [15:0] tail_len;
        logic [15:0] body_num;
    } frame_cfg_t;

    // DMA beat, written whole and read back lane by lane, lane 0 lowest
    typedef union packed {
        logic [63:0]      word;
        logic [3:0][15:0] lane;
    } dma_word_u;

    typedef struct packed {
        logic      fifo_empty;
        logic      fifo_full;
        tx_state_e state;
    } tx_status_t;

    // only the low byte of a comma is a K character
    localparam line_sym_t COMMA_SYM = line_sym_t'({1'b0, 1'b1, D5_6, K28_5});
    localparam line_sym_t SOF_SYM   = line_sym_t'({1'b1, 1'b1, K28_2, K27_7});
    localparam line_sym_t EOF_SYM   = line_sym_t'({1'b1, 1'b1, K29_7, K30_7});

endpackage

`default_nettype wire

//--- tlk_tx_fifo.sv
// first-word-fall-through FIFO, 64-bit writes and 16-bit lane reads
// FIFO_DEPTH must be a power of two; the writer must not push while full
`timescale 1ns/1ps
`default_nettype none

module tlk_tx_fifo #(
    parameter int FIFO_DEPTH = 512
) (
    input  wire                    clk,
    input  wire                    i_soft_reset,
    input  wire                    i_wr,
    input  tlk_tx_pkg::dma_word_u  i_wdata,
    input  wire                    i_pop,
    input  wire                    i_drop_rest,
    output logic [15:0]            o_lane,
    output logic                   o_empty,
    output logic                   o_full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    tlk_tx_pkg::dma_word_u mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [1:0]    lane_ptr;
    logic          pop_ok;
    logic          release_word;

    assign pop_ok = i_pop & ~o_empty;

    // word leaves after its last lane, or early when the frame ends inside it
    assign release_word = pop_ok & (i_drop_rest | (lane_ptr == 2'd3));

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[wr_ptr].word <= i_wdata.word;
        end
    end

    // head word is always visible, lane picked by the lane pointer
    assign o_lane = mem[rd_ptr].lane[lane_ptr];

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            lane_ptr <= 2'd0;
        end else begin
            if (i_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (release_word) begin
                rd_ptr   <= rd_ptr + 1'b1;
                lane_ptr <= 2'd0;
            end else if (pop_ok) begin
                lane_ptr <= lane_ptr + 2'd1;
            end

            case ({i_wr, release_word})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // count is in whole words, a part-read word still counts
    assign o_empty = (count == '0);
    assign o_full  = (count == (AW+1)'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- tlk_tx_framer.sv
// frame sequencer; SYNC_LEN and GAP_LEN must be at least 1
// i_cfg must stay stable while a transfer runs
`timescale 1ns/1ps
`default_nettype none

module tlk_tx_framer #(
    parameter int SYNC_LEN = 6,
    parameter int GAP_LEN  = 256
) (
    input  wire                     clk,
    input  wire                     i_soft_reset,
    input  wire                     i_armed,
    input  tlk_tx_pkg::frame_cfg_t  i_cfg,
    input  wire                     i_fifo_empty,
    input  wire [15:0]              i_lane,
    output logic                    o_pop,
    output logic                    o_drop_rest,
    output tlk_tx_pkg::line_sym_t   o_sym,
    output logic                    o_sum_en,
    output logic                    o_tail,
    output tlk_tx_pkg::tx_state_e   o_state,
    output logic                    o_tx_interrupt
);

    localparam logic [15:0] SYNC_LAST = 16'(SYNC_LEN - 1);
    localparam logic [15:0] GAP_LAST  = 16'(GAP_LEN - 1);

    tlk_tx_pkg::tx_state_e st;

    // shared down-counter for sync, header, data and gap phases
    logic [15:0] cnt;
    logic [15:0] frame_cnt;
    logic        is_last;
    logic [15:0] frame_len;

    assign is_last   = (frame_cnt == i_cfg.body_num);
    assign frame_len = is_last ? i_cfg.tail_len : i_cfg.body_len;
    assign o_state   = st;

    ////////////////////////////////////////////////////////////
    // state, counters and interrupt
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            st             <= tlk_tx_pkg::idle;
            cnt            <= '0;
            frame_cnt      <= '0;
            o_tx_interrupt <= 1'b0;
        end else begin
            o_tx_interrupt <= (st == tlk_tx_pkg::gap) && (cnt == '0) && is_last;
            case (st)
                tlk_tx_pkg::idle: begin
                    if (i_armed && !i_fifo_empty) begin
                        st        <= tlk_tx_pkg::sync;
                        cnt       <= SYNC_LAST;
                        frame_cnt <= '0;
                    end
                end
                tlk_tx_pkg::sync: begin
                    if (cnt == '0) st <= tlk_tx_pkg::sof;
                    else           cnt <= cnt - 16'd1;
                end
                tlk_tx_pkg::sof: begin
                    st  <= tlk_tx_pkg::head;
                    cnt <= 16'd1;
                end
                tlk_tx_pkg::head: begin
                    if (cnt == '0) st <= tlk_tx_pkg::file_sign;
                    else           cnt <= cnt - 16'd1;
                end
                tlk_tx_pkg::file_sign: st <= tlk_tx_pkg::frame_num;
                tlk_tx_pkg::frame_num: st <= tlk_tx_pkg::dlen;
                tlk_tx_pkg::dlen: begin
                    st  <= tlk_tx_pkg::data;
                    cnt <= {1'b0, frame_len[15:1]} - 16'd1;
                end
                tlk_tx_pkg::data: begin
                    // stall cycles do not count
                    if (!i_fifo_empty) begin
                        if (cnt == '0) st <= tlk_tx_pkg::tail;
                        else           cnt <= cnt - 16'd1;
                    end
                end
                tlk_tx_pkg::tail: st <= tlk_tx_pkg::eof;
                tlk_tx_pkg::eof: begin
                    st  <= tlk_tx_pkg::gap;
                    cnt <= GAP_LAST;
                end
                tlk_tx_pkg::gap: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 16'd1;
                    end else if (is_last) begin
                        st <= tlk_tx_pkg::idle;
                    end else begin
                        st        <= tlk_tx_pkg::sof;
                        frame_cnt <= frame_cnt + 16'd1;
                    end
                end
                default: st <= tlk_tx_pkg::idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // symbol selection
    ////////////////////////////////////////////////////////////
    always_comb begin
        o_sym       = '0;
        o_pop       = 1'b0;
        o_drop_rest = 1'b0;
        o_sum_en    = 1'b0;
        o_tail      = 1'b0;
        case (st)
            tlk_tx_pkg::sync, tlk_tx_pkg::gap: o_sym = tlk_tx_pkg::COMMA_SYM;
            tlk_tx_pkg::sof: o_sym = tlk_tx_pkg::SOF_SYM;
            tlk_tx_pkg::head: o_sym.data = cnt[0] ? tlk_tx_pkg::HEAD_0 : tlk_tx_pkg::HEAD_1;
            tlk_tx_pkg::file_sign: begin
                o_sym.data = {tlk_tx_pkg::TX_IND, is_last ? tlk_tx_pkg::FILE_END : 8'h00};
            end
            tlk_tx_pkg::frame_num: begin
                o_sym.data = frame_cnt;
                o_sum_en   = 1'b1;
            end
            tlk_tx_pkg::dlen: begin
                o_sym.data = frame_len;
                o_sum_en   = 1'b1;
            end
            tlk_tx_pkg::data: begin
                if (i_fifo_empty) begin
                    // filler while the DMA catches up
                    o_sym = tlk_tx_pkg::COMMA_SYM;
                end else begin
                    o_sym.data  = i_lane;
                    o_pop       = 1'b1;
                    o_sum_en    = 1'b1;
                    o_drop_rest = (cnt == '0);
                end
            end
            // data left zero, the line stage fills in the checksum
            tlk_tx_pkg::tail: o_tail = 1'b1;
            tlk_tx_pkg::eof: o_sym = tlk_tx_pkg::EOF_SYM;
            default: o_sym = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- tlk_tx_line_out.sv
// checksum and output register stage, exactly one cycle of latency
// sum is modulo 65536 and restarts on every SOF symbol
`timescale 1ns/1ps
`default_nettype none

module tlk_tx_line_out (
    input  wire                    clk,
    input  wire                    i_soft_reset,
    input  tlk_tx_pkg::line_sym_t  i_sym,
    input  wire                    i_sum_en,
    input  wire                    i_tail,
    output tlk_tx_pkg::line_sym_t  o_line
);

    logic [15:0] sum;
    logic        is_sof;

    assign is_sof = (i_sym == tlk_tx_pkg::SOF_SYM);

    ////////////////////////////////////////////////////////////
    // running sum over frame number, length and data words
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            sum <= '0;
        end else if (is_sof) begin
            sum <= '0;
        end else if (i_sum_en) begin
            sum <= sum + i_sym.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // line register
    ////////////////////////////////////////////////////////////
    // tail word arrives right after the last data word, so sum is complete
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_line <= '0;
        end else if (i_tail) begin
            o_line.tk_msb <= i_sym.tk_msb;
            o_line.tk_lsb <= i_sym.tk_lsb;
            o_line.data   <= sum;
        end else begin
            o_line <= i_sym;
        end
    end

endmodule

`default_nettype wire

//--- tlk_tx_top.sv
// TLK2711 transmit framer top, normal mode only
// DMA writes stay enabled from the first start until a soft reset
`timescale 1ns/1ps
`default_nettype none

module tlk_tx_top #(
    parameter int FIFO_DEPTH = 512,
    parameter int SYNC_LEN   = 6,
    parameter int GAP_LEN    = 256
) (
    input  wire                     clk,
    input  wire                     i_soft_reset,
    input  wire                     i_tx_start,
    input  tlk_tx_pkg::frame_cfg_t  i_cfg,
    input  wire                     i_dma_valid,
    input  tlk_tx_pkg::dma_word_u   i_dma_data,
    output logic                    o_dma_ready,
    output tlk_tx_pkg::line_sym_t   o_line,
    output logic                    o_tx_interrupt,
    output tlk_tx_pkg::tx_status_t  o_status
);

    tlk_tx_pkg::frame_cfg_t cfg_q;
    tlk_tx_pkg::line_sym_t  sym;
    tlk_tx_pkg::tx_state_e  state;

    logic        armed;
    logic        wr_en;
    logic        fifo_wr;
    logic        fifo_empty;
    logic        fifo_full;
    logic        pop;
    logic        drop_rest;
    logic        sum_en;
    logic        tail;
    logic [15:0] lane;

    // held copy, only read while a transfer runs
    always_ff @(posedge clk) begin
        if (i_tx_start) begin
            cfg_q <= i_cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            armed <= 1'b0;
            wr_en <= 1'b0;
        end else begin
            if (i_tx_start) begin
                armed <= 1'b1;
                wr_en <= 1'b1;
            end else if (state == tlk_tx_pkg::gap) begin
                armed <= 1'b0;
            end
        end
    end

    assign o_dma_ready = ~fifo_full;
    assign fifo_wr     = i_dma_valid & o_dma_ready & wr_en;

    tlk_tx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) tlk_tx_fifo_inst (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_wr         (fifo_wr),
        .i_wdata      (i_dma_data),
        .i_pop        (pop),
        .i_drop_rest  (drop_rest),
        .o_lane       (lane),
        .o_empty      (fifo_empty),
        .o_full       (fifo_full)
    );

    tlk_tx_framer #(
        .SYNC_LEN (SYNC_LEN),
        .GAP_LEN  (GAP_LEN)
    ) tlk_tx_framer_inst (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_armed        (armed),
        .i_cfg          (cfg_q),
        .i_fifo_empty   (fifo_empty),
        .i_lane         (lane),
        .o_pop          (pop),
        .o_drop_rest    (drop_rest),
        .o_sym          (sym),
        .o_sum_en       (sum_en),
        .o_tail         (tail),
        .o_state        (state),
        .o_tx_interrupt (o_tx_interrupt)
    );

    tlk_tx_line_out tlk_tx_line_out_inst (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_sym        (sym),
        .i_sum_en     (sum_en),
        .i_tail       (tail),
        .o_line       (o_line)
    );

    assign o_status.fifo_empty = fifo_empty;
    assign o_status.fifo_full  = fifo_full;
    assign o_status.state      = state;

endmodule

`default_nettype wire

//--- tlk_tx_properties.sv
// bound checks on line output, interrupt and FIFO strobes
// all properties are disabled during soft reset
`timescale 1ns/1ps
`default_nettype none

module tlk_tx_properties (
    input wire                    clk,
    input wire                    i_soft_reset,
    input wire                    o_tx_interrupt,
    input wire                    o_dma_ready,
    input wire                    fifo_wr,
    input wire                    fifo_empty,
    input tlk_tx_pkg::line_sym_t  o_line
);

    irq_one_cycle: assert property (@(posedge clk) disable iff (i_soft_reset)
        o_tx_interrupt |=> !o_tx_interrupt)
        else $error("interrupt wider than one cycle");

    // ready only drops when a write takes the last free slot
    ready_fall_on_write: assert property (@(posedge clk) disable iff (i_soft_reset)
        $fell(o_dma_ready) |-> $past(fifo_wr))
        else $error("dma ready fell without a write");

    // msb K flag belongs to SOF and EOF only
    msb_only_sof_eof: assert property (@(posedge clk) disable iff (i_soft_reset)
        o_line.tk_msb |-> (o_line == tlk_tx_pkg::SOF_SYM || o_line == tlk_tx_pkg::EOF_SYM))
        else $error("tk_msb on a word other than SOF or EOF");

    write_not_lost: assert property (@(posedge clk) disable iff (i_soft_reset)
        fifo_wr |=> !fifo_empty)
        else $error("FIFO empty right after a write");

endmodule

bind tlk_tx_top tlk_tx_properties tlk_tx_properties_inst (
    .clk            (clk),
    .i_soft_reset   (i_soft_reset),
    .o_tx_interrupt (o_tx_interrupt),
    .o_dma_ready    (o_dma_ready),
    .fifo_wr        (fifo_wr),
    .fifo_empty     (fifo_empty),
    .o_line         (o_line)
);

`default_nettype wire

//--- tb_tlk_tx.sv
// testbench for the TLK2711 transmit framer, small FIFO and short gap for run time
// each transfer consumes exactly the DMA words generated for it
`timescale 1ns/1ps
`default_nettype none

module tb_tlk_tx;

    localparam int FIFO_DEPTH   = 16;
    localparam int SYNC_LEN     = 6;
    localparam int GAP_LEN      = 20;
    localparam int TOTAL_FRAMES = 13;
    localparam int CYCLE_LIMIT  = TOTAL_FRAMES * (GAP_LEN + 600);

    logic                   clk;
    logic                   i_soft_reset;
    logic                   i_tx_start;
    tlk_tx_pkg::frame_cfg_t i_cfg;
    logic                   i_dma_valid;
    tlk_tx_pkg::dma_word_u  i_dma_data;
    logic                   o_dma_ready;
    tlk_tx_pkg::line_sym_t  o_line;
    logic                   o_tx_interrupt;
    tlk_tx_pkg::tx_status_t o_status;

    tlk_tx_pkg::dma_word_u dma_q[$];
    tlk_tx_pkg::dma_word_u model_q[$];
    tlk_tx_pkg::line_sym_t exp_q[$];
    bit                    exp_is_data_q[$];

    bit dma_en;
    bit cmp_on;
    bit seen;
    int irq_cnt;
    int cycles;

    tlk_tx_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .SYNC_LEN   (SYNC_LEN),
        .GAP_LEN    (GAP_LEN)
    ) tlk_tx_top_inst (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_tx_start     (i_tx_start),
        .i_cfg          (i_cfg),
        .i_dma_valid    (i_dma_valid),
        .i_dma_data     (i_dma_data),
        .o_dma_ready    (o_dma_ready),
        .o_line         (o_line),
        .o_tx_interrupt (o_tx_interrupt),
        .o_status       (o_status)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic void expect_sym(tlk_tx_pkg::line_sym_t s, bit is_data);
        exp_q.push_back(s);
        exp_is_data_q.push_back(is_data);
    endfunction

    function automatic void add_transfer(tlk_tx_pkg::frame_cfg_t cfg);
        tlk_tx_pkg::line_sym_t comma;
        logic [15:0] len;
        logic [15:0] sum;
        logic [15:0] lane;
        bit          last;
        comma = '{tk_msb: 1'b0, tk_lsb: 1'b1, data: {tlk_tx_pkg::D5_6, tlk_tx_pkg::K28_5}};
        for (int i = 0; i < SYNC_LEN; i++) expect_sym(comma, 1'b0);
        for (int f = 0; f <= int'(cfg.body_num); f++) begin
            last = (f == int'(cfg.body_num));
            len  = last ? cfg.tail_len : cfg.body_len;
            expect_sym('{1'b1, 1'b1, {tlk_tx_pkg::K28_2, tlk_tx_pkg::K27_7}}, 1'b0);
            expect_sym('{1'b0, 1'b0, tlk_tx_pkg::HEAD_0}, 1'b0);
            expect_sym('{1'b0, 1'b0, tlk_tx_pkg::HEAD_1}, 1'b0);
            expect_sym('{1'b0, 1'b0, {tlk_tx_pkg::TX_IND,
                                       last ? tlk_tx_pkg::FILE_END : 8'h00}}, 1'b0);
            expect_sym('{1'b0, 1'b0, 16'(f)}, 1'b0);
            expect_sym('{1'b0, 1'b0, len}, 1'b0);
            sum = 16'(f) + len;
            for (int i = 0; i < int'(len) / 2; i++) begin
                lane = model_q[i / 4].lane[i % 4];
                sum  = sum + lane;
                expect_sym('{1'b0, 1'b0, lane}, 1'b1);
            end
            // each frame starts on a fresh DMA word
            for (int w = 0; w < (int'(len) / 2 + 3) / 4; w++) void'(model_q.pop_front());
            expect_sym('{1'b0, 1'b0, sum}, 1'b0);
            expect_sym('{1'b1, 1'b1, {tlk_tx_pkg::K29_7, tlk_tx_pkg::K30_7}}, 1'b0);
            for (int i = 0; i < GAP_LEN; i++) expect_sym(comma, 1'b0);
        end
    endfunction

    function automatic int words_for(tlk_tx_pkg::frame_cfg_t cfg);
        int n;
        n = 0;
        for (int f = 0; f <= int'(cfg.body_num); f++) begin
            n += ((f == int'(cfg.body_num) ? int'(cfg.tail_len) : int'(cfg.body_len)) / 2 + 3) / 4;
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // DMA driver, compare process, interrupt count, timeout
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (i_dma_valid && o_dma_ready) void'(dma_q.pop_front());
        #1;
        i_dma_valid = dma_en && (dma_q.size() > 0) && ($urandom % 4 != 0);
        i_dma_data  = (dma_q.size() > 0) ? dma_q[0] : '0;
    end

    always @(negedge clk) begin
        if (o_tx_interrupt) irq_cnt++;
        if (cmp_on && exp_q.size() > 0 && (seen || o_line != '0)) begin
            seen = 1'b1;
            // stall commas inside the data phase are not part of the frame
            if (!(exp_is_data_q[0] && o_line.tk_lsb)) begin
                check("o_line", 32'(o_line), 32'(exp_q[0]));
                // pulse comes with the last gap comma of the transfer
                check("o_tx_interrupt", 32'(o_tx_interrupt), 32'(exp_q.size() == 1));
                void'(exp_q.pop_front());
                void'(exp_is_data_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, transfer did not complete", cycles);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    task automatic gen_words(input int n);
        tlk_tx_pkg::dma_word_u w;
        for (int i = 0; i < n; i++) begin
            w.word = {$urandom, $urandom};
            dma_q.push_back(w);
            model_q.push_back(w);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        i_soft_reset = 1'b1;
        i_dma_valid  = 1'b0;
        dma_en       = 1'b0;
        cmp_on       = 1'b0;
        dma_q.delete();
        model_q.delete();
        exp_q.delete();
        exp_is_data_q.delete();
        repeat (3) @(posedge clk);
        #1;
        i_soft_reset = 1'b0;
        irq_cnt      = 0;
    endtask

    task automatic start_transfer(input tlk_tx_pkg::frame_cfg_t cfg);
        @(posedge clk);
        #1;
        i_cfg      = cfg;
        i_tx_start = 1'b1;
        @(posedge clk);
        dma_en = 1'b1;
        #1;
        i_tx_start = 1'b0;
    endtask

    task automatic run_transfer(input tlk_tx_pkg::frame_cfg_t cfg);
        gen_words(words_for(cfg) - model_q.size());
        add_transfer(cfg);
        irq_cnt = 0;
        seen    = 1'b0;
        cmp_on  = 1'b1;
        start_transfer(cfg);
        while (exp_q.size() != 0 || irq_cnt == 0) @(posedge clk);
        repeat (GAP_LEN) @(posedge clk);
        check("o_tx_interrupt count", 32'(irq_cnt), 32'd1);
        cmp_on = 1'b0;
    endtask

    initial begin
        void'($urandom(97509));
        clk          = 1'b0;
        i_soft_reset = 1'b1;
        i_tx_start   = 1'b0;
        i_cfg        = '0;
        i_dma_valid  = 1'b0;
        i_dma_data   = '0;
        apply_reset();

        // idle after reset
        repeat (10) begin
            @(negedge clk);
            check("o_line", 32'(o_line), 32'd0);
            check("o_tx_interrupt", 32'(o_tx_interrupt), 32'd0);
            check("o_dma_ready", 32'(o_dma_ready), 32'd1);
            check("o_status", 32'(o_status), 32'({1'b1, 1'b0, tlk_tx_pkg::idle}));
        end

        run_transfer('{body_len: 16'd16, tail_len: 16'd16, body_num: 16'd0});
        run_transfer('{body_len: 16'd24, tail_len: 16'd8, body_num: 16'd2});
        // six lanes per frame, rest of the second word is dropped
        run_transfer('{body_len: 16'd12, tail_len: 16'd12, body_num: 16'd1});

        // fill the FIFO while the framer is idle
        gen_words(FIFO_DEPTH + 4);
        while (o_dma_ready) @(negedge clk);
        check("o_status", 32'(o_status), 32'({1'b0, 1'b1, tlk_tx_pkg::idle}));
        run_transfer('{body_len: 16'd64, tail_len: 16'd32, body_num: 16'd2});

        // abort mid-frame, then a clean transfer from frame 0
        apply_reset();
        gen_words(8);
        start_transfer('{body_len: 16'd32, tail_len: 16'd32, body_num: 16'd1});
        while (o_status.state != tlk_tx_pkg::data) @(posedge clk);
        repeat (3) @(posedge clk);
        apply_reset();
        repeat (4) begin
            @(negedge clk);
            check("o_line", 32'(o_line), 32'd0);
        end
        run_transfer('{body_len: 16'd20, tail_len: 16'd10, body_num: 16'd1});

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
tlk_tx_pkg.sv
tlk_tx_fifo.sv
tlk_tx_framer.sv
tlk_tx_line_out.sv
tlk_tx_top.sv
tlk_tx_properties.sv
tb_tlk_tx.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tlk_tx
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat src.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) src.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f src.f

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
